//--- verilog/msx_mapper_pkg.sv
package msx_mapper_pkg;

   // Linear memory address seen by the RAM/ROM port
   localparam int MEM_ADDR_W = 27;

   // Offsets produced by megaROM mappers
   localparam int ROM_ADDR_W = 25;

   localparam int BANK_W = 8;   // Cartridge bank register width

   // Kind of mapping behind one 16 KB block of a (sub)slot
   typedef enum logic [2:0] {
      MAPPER_UNUSED  = 3'd0,
      MAPPER_NONE    = 3'd1,
      MAPPER_LINEAR  = 3'd2,
      MAPPER_RAM     = 3'd3,
      MAPPER_KONAMI  = 3'd4,
      MAPPER_ASCII16 = 3'd5
   } mapper_typ_t;

endpackage

//--- verilog/msx_cfg_pkg.sv
package msx_cfg_pkg;

   import msx_mapper_pkg::*;

   // One entry per slot x subslot x block
   localparam int LAYOUT_ENTRIES = 64;

   // Memory regions referenced from the layout
   localparam int RAM_REGIONS = 16;

   // Layout entry
   typedef struct packed {
      mapper_typ_t mapper;
      logic  [3:0] ref_ram;      // Index into lookup_RAM
      logic  [1:0] offset_ram;   // Start block, NONE only
   } block_t;

   // Memory region
   typedef struct packed {
      logic [MEM_ADDR_W-1:0] addr;   // Base in linear memory
      logic           [15:0] size;   // 16 KB units
      logic                  ro;     // Writes suppressed
   } lookup_RAM_t;

endpackage

//--- verilog/slot_expander.sv
module slot_expander
(
   input               clk,
   input               reset,
   input        [15:0] cpu_addr,
   input         [7:0] cpu_dout,
   input               cpu_wr,
   input               cpu_rd,
   input               cpu_mreq,
   input         [1:0] active_slot,
   input         [3:0] expander_en,
   input         [1:0] block,
   output logic  [1:0] subslot,
   output logic  [7:0] exp_dout,
   output logic        exp_rd
);

   logic [7:0] sub_reg [4];
   logic       exp_en;

   // Subslot register lives at FFFF of an expanded primary slot
   assign exp_en = (cpu_addr == 16'hFFFF) & expander_en[active_slot] & cpu_mreq;
   assign exp_rd = exp_en & cpu_rd;

   assign exp_dout = exp_rd ? ~sub_reg[active_slot] : 8'hFF;   // Reads back inverted

   // Two bits per 16 KB block
   assign subslot = expander_en[active_slot] ? sub_reg[active_slot][{block, 1'b0} +: 2]
                                             : 2'd0;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 4; i++)
            sub_reg[i] <= 8'h00;
      end else if (exp_en & cpu_wr) begin
         sub_reg[active_slot] <= cpu_dout;
      end
   end

endmodule

//--- verilog/msx2_ram_mapper.sv
module msx2_ram_mapper
#(
   parameter int RAM_SEG_BITS = 8
)
(
   input               clk,
   input               reset,
   input        [15:0] cpu_addr,
   input         [7:0] cpu_dout,
   input               cpu_wr,
   input               cpu_rd,
   input               cpu_iorq,
   input               cpu_m1,
   input         [7:0] ram_block_count,
   output logic [21:0] mapper_addr,
   output logic  [7:0] mapper_dout
);

   // Bits carried by a segment register
   localparam logic [7:0] SEG_MASK = 8'((9'd1 << RAM_SEG_BITS) - 9'd1);

   logic [RAM_SEG_BITS-1:0] seg [4];
   logic                    port_hit;
   logic                    io_wr;
   logic                    io_rd;
   logic              [7:0] page_seg;
   logic              [7:0] seg_masked;

   assign port_hit = cpu_addr[7:2] == 6'b111111;   // FC - FF
   assign io_wr    = port_hit & cpu_iorq & cpu_wr & ~cpu_m1;
   assign io_rd    = port_hit & cpu_iorq & cpu_rd & ~cpu_m1;

   always_ff @(posedge clk) begin
      if (reset) begin
         // FC -> 3, FD -> 2, FE -> 1, FF -> 0
         for (int i = 0; i < 4; i++)
            seg[i] <= RAM_SEG_BITS'(3 - i);
      end else if (io_wr) begin
         seg[cpu_addr[1:0]] <= cpu_dout[RAM_SEG_BITS-1:0];
      end
   end

   // Unused upper bits read as 1
   assign mapper_dout = io_rd ? (8'(seg[cpu_addr[1:0]]) | ~SEG_MASK) : 8'hFF;

   // Segment of the current page, wrapped to the installed RAM
   assign page_seg   = 8'(seg[cpu_addr[15:14]]);
   assign seg_masked = page_seg & (ram_block_count - 8'd1);

   assign mapper_addr = {seg_masked, cpu_addr[13:0]};

endmodule

//--- verilog/cart_konami.sv
module cart_konami import msx_mapper_pkg::*;
(
   input                         clk,
   input                         reset,
   input                         cs,
   input                  [15:0] cpu_addr,
   input                   [7:0] din,
   input                         cpu_wr,
   input                         cpu_mreq,
   input        [ROM_ADDR_W-1:0] rom_size,
   output logic [ROM_ADDR_W-1:0] mem_addr,
   output logic                  mem_unmaped
);

   logic [BANK_W-1:0] bank [1:3];   // Bank 0 is hardwired
   logic [BANK_W-1:0] bank_sel;
   logic        [2:0] win;
   logic        [1:0] idx;
   logic              in_window;

   // 4000 -> 0, 6000 -> 1, 8000 -> 2, A000 -> 3, anything else has bit 2 set
   assign win       = cpu_addr[15:13] - 3'd2;
   assign idx       = win[1:0];
   assign in_window = ~win[2];

   always_ff @(posedge clk) begin
      if (reset) begin
         bank[1] <= BANK_W'(1);
         bank[2] <= BANK_W'(2);
         bank[3] <= BANK_W'(3);
      end else if (cs & cpu_mreq & cpu_wr & in_window & (idx != 2'd0)) begin
         bank[idx] <= din;
      end
   end

   always_comb begin
      case (idx)
         2'd1:    bank_sel = bank[1];
         2'd2:    bank_sel = bank[2];
         2'd3:    bank_sel = bank[3];
         default: bank_sel = '0;
      endcase
   end

   // 8 KB pages, wrapped by the ROM image size
   assign mem_addr    = ROM_ADDR_W'({bank_sel, cpu_addr[12:0]}) & (rom_size - ROM_ADDR_W'(1));
   assign mem_unmaped = cs & ~in_window;

endmodule

//--- verilog/cart_ascii16.sv
module cart_ascii16 import msx_mapper_pkg::*;
(
   input                         clk,
   input                         reset,
   input                         cs,
   input                  [15:0] cpu_addr,
   input                   [7:0] din,
   input                         cpu_wr,
   input                         cpu_mreq,
   input        [ROM_ADDR_W-1:0] rom_size,
   output logic [ROM_ADDR_W-1:0] mem_addr,
   output logic                  mem_unmaped
);

   logic [BANK_W-1:0] bank0;   // 4000 - 7FFF
   logic [BANK_W-1:0] bank1;   // 8000 - BFFF
   logic              cart_wr;
   logic              in_window;

   assign cart_wr   = cs & cpu_mreq & cpu_wr;
   assign in_window = cpu_addr[15] ^ cpu_addr[14];

   always_ff @(posedge clk) begin
      if (reset) begin
         bank0 <= '0;
         bank1 <= '0;
      end else if (cart_wr) begin
         if (cpu_addr[15:11] == 5'b01100)   // 6000 - 67FF
            bank0 <= din;
         if (cpu_addr[15:11] == 5'b01110)   // 7000 - 77FF
            bank1 <= din;
      end
   end

   // 16 KB pages
   assign mem_addr = ROM_ADDR_W'({cpu_addr[15] ? bank1 : bank0, cpu_addr[13:0]})
                   & (rom_size - ROM_ADDR_W'(1));

   assign mem_unmaped = cs & ~in_window;

endmodule

//--- verilog/msx_slots.sv
module msx_slots import msx_mapper_pkg::*, msx_cfg_pkg::*;
#(
   parameter int RAM_SEG_BITS = 8
)
(
   input                         clk,
   input                         reset,
   // CPU
   input                  [15:0] cpu_addr,
   input                   [7:0] cpu_dout,
   output logic            [7:0] cpu_din,
   input                         cpu_wr,
   input                         cpu_rd,
   input                         cpu_mreq,
   input                         cpu_iorq,
   input                         cpu_m1,
   // Configuration
   input                   [1:0] active_slot,
   input                   [3:0] expander_en,
   input                   [7:0] ram_block_count,
   input  block_t                slot_layout [LAYOUT_ENTRIES],
   input  lookup_RAM_t           lookup_RAM [RAM_REGIONS],
   // Memory
   output logic [MEM_ADDR_W-1:0] ram_addr,
   output logic            [7:0] ram_din,
   input                   [7:0] ram_dout,
   output logic                  ram_rnw,
   output logic                  ram_ce
);

   logic            [1:0] block;
   logic            [1:0] subslot;
   logic            [5:0] layout_id;
   mapper_typ_t           mapper;
   logic            [3:0] ref_ram;
   logic            [1:0] offset_ram;
   logic [MEM_ADDR_W-1:0] base_ram;
   logic           [15:0] size;
   logic                  ram_ro;
   logic [ROM_ADDR_W-1:0] rom_size;
   logic [MEM_ADDR_W-1:0] none_addr;
   logic [MEM_ADDR_W-1:0] linear_addr;
   logic [MEM_ADDR_W-1:0] mapper_addr;
   logic                  mem_acc;
   logic                  mem_unmaped;
   logic            [7:0] exp_dout;
   logic                  exp_rd;
   logic           [21:0] ram_map_addr;
   logic            [7:0] ram_map_dout;
   logic [ROM_ADDR_W-1:0] konami_addr;
   logic                  konami_unmaped;
   logic [ROM_ADDR_W-1:0] ascii16_addr;
   logic                  ascii16_unmaped;

   assign block = cpu_addr[15:14];

   slot_expander expander
   (
      .clk(clk),
      .reset(reset),
      .cpu_addr(cpu_addr),
      .cpu_dout(cpu_dout),
      .cpu_wr(cpu_wr),
      .cpu_rd(cpu_rd),
      .cpu_mreq(cpu_mreq),
      .active_slot(active_slot),
      .expander_en(expander_en),
      .block(block),
      .subslot(subslot),
      .exp_dout(exp_dout),
      .exp_rd(exp_rd)
   );

   // Layout and region lookup
   assign layout_id  = {active_slot, subslot, block};
   assign mapper     = slot_layout[layout_id].mapper;
   assign ref_ram    = slot_layout[layout_id].ref_ram;
   assign offset_ram = slot_layout[layout_id].offset_ram;
   assign base_ram   = lookup_RAM[ref_ram].addr;
   assign size       = lookup_RAM[ref_ram].size;   // 16 KB * size
   assign ram_ro     = lookup_RAM[ref_ram].ro;

   assign rom_size = ROM_ADDR_W'(size) << 14;

   assign none_addr   = MEM_ADDR_W'(cpu_addr[13:0]) + (MEM_ADDR_W'(offset_ram) << 14);
   assign linear_addr = MEM_ADDR_W'(cpu_addr) & ((MEM_ADDR_W'(size) << 14) - MEM_ADDR_W'(1));

   msx2_ram_mapper #(
      .RAM_SEG_BITS(RAM_SEG_BITS)
   ) ram_mapper (
      .clk(clk),
      .reset(reset),
      .cpu_addr(cpu_addr),
      .cpu_dout(cpu_dout),
      .cpu_wr(cpu_wr),
      .cpu_rd(cpu_rd),
      .cpu_iorq(cpu_iorq),
      .cpu_m1(cpu_m1),
      .ram_block_count(ram_block_count),
      .mapper_addr(ram_map_addr),
      .mapper_dout(ram_map_dout)
   );

   cart_konami konami
   (
      .clk(clk),
      .reset(reset),
      .cs(mapper == MAPPER_KONAMI),
      .cpu_addr(cpu_addr),
      .din(cpu_dout),
      .cpu_wr(cpu_wr),
      .cpu_mreq(cpu_mreq),
      .rom_size(rom_size),
      .mem_addr(konami_addr),
      .mem_unmaped(konami_unmaped)
   );

   cart_ascii16 ascii16
   (
      .clk(clk),
      .reset(reset),
      .cs(mapper == MAPPER_ASCII16),
      .cpu_addr(cpu_addr),
      .din(cpu_dout),
      .cpu_wr(cpu_wr),
      .cpu_mreq(cpu_mreq),
      .rom_size(rom_size),
      .mem_addr(ascii16_addr),
      .mem_unmaped(ascii16_unmaped)
   );

   always_comb begin
      case (mapper)
         MAPPER_NONE:    mapper_addr = none_addr;
         MAPPER_LINEAR:  mapper_addr = linear_addr;
         MAPPER_RAM:     mapper_addr = MEM_ADDR_W'(ram_map_addr);
         MAPPER_KONAMI:  mapper_addr = MEM_ADDR_W'(konami_addr);
         MAPPER_ASCII16: mapper_addr = MEM_ADDR_W'(ascii16_addr);
         default:        mapper_addr = '0;
      endcase
   end

   assign ram_addr = base_ram + mapper_addr;

   // Expander read at FFFF must not reach memory
   assign mem_unmaped = (mapper == MAPPER_UNUSED) | konami_unmaped | ascii16_unmaped | exp_rd;

   assign mem_acc = cpu_mreq & (cpu_rd | cpu_wr);
   assign ram_ce  = mem_acc & ~mem_unmaped & ~(cpu_wr & ram_ro);   // ROM write protect
   assign ram_rnw = cpu_mreq & ~cpu_wr;
   assign ram_din = cpu_dout;

   // Every source idles at FF
   assign cpu_din = exp_dout
                  & ram_map_dout   // IO
                  & ((mem_acc & cpu_rd & ~mem_unmaped) ? ram_dout : 8'hFF);

endmodule

//--- tb/msx_slots_properties.sv
module msx_slots_properties (
   input logic clk,
   input logic reset,
   input logic cpu_mreq,
   input logic cpu_wr,
   input logic ram_ro,
   input logic ram_ce,
   input logic ram_rnw
);

   timeunit 1ns;
   timeprecision 1ps;

   // Memory enable only inside a memory cycle
   a_ce_needs_mreq: assert property (@(posedge clk) disable iff (reset)
      ram_ce |-> cpu_mreq)
      else $error("ram_ce high without cpu_mreq");

   a_write_direction: assert property (@(posedge clk) disable iff (reset)
      (ram_ce && cpu_wr) |-> !ram_rnw)
      else $error("ram_rnw high on an enabled write");

   // Read-only regions
   a_ro_protect: assert property (@(posedge clk) disable iff (reset)
      (cpu_mreq && cpu_wr && ram_ro) |-> !ram_ce)
      else $error("write reached a read-only region");

endmodule

bind msx_slots msx_slots_properties u_props (
   .clk(clk),
   .reset(reset),
   .cpu_mreq(cpu_mreq),
   .cpu_wr(cpu_wr),
   .ram_ro(ram_ro),
   .ram_ce(ram_ce),
   .ram_rnw(ram_rnw)
);

//--- tb/msx_slots_checker.sv
module msx_slots_checker import msx_mapper_pkg::*, msx_cfg_pkg::*;
#(
   parameter int RAM_SEG_BITS = 8
)
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic           [15:0] cpu_addr,
   input  logic            [7:0] cpu_dout,
   input  logic            [7:0] cpu_din,
   input  logic                  cpu_wr,
   input  logic                  cpu_rd,
   input  logic                  cpu_mreq,
   input  logic                  cpu_iorq,
   input  logic                  cpu_m1,
   input  logic            [1:0] active_slot,
   input  logic            [3:0] expander_en,
   input  logic            [7:0] ram_block_count,
   input  block_t                slot_layout [LAYOUT_ENTRIES],
   input  lookup_RAM_t           lookup_RAM [RAM_REGIONS],
   input  logic [MEM_ADDR_W-1:0] ram_addr,
   input  logic            [7:0] ram_din,
   input  logic                  ram_rnw,
   input  logic                  ram_ce,
   input  logic                  test_end,
   input  int                    test_num,
   output int                    errors,
   output int                    checks
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [7:0] SEG_HIGH = 8'hFF << RAM_SEG_BITS;   // Above the segment register

   logic [7:0] exp_reg [4];
   logic [7:0] seg_reg [4];
   logic [7:0] kbank [4];   // Entry 0 stays 0
   logic [7:0] abank [2];
   int         test_errors;

   function automatic block_t entry_now();
      logic [1:0] blk;
      logic [1:0] sub;
      blk = cpu_addr[15:14];
      sub = expander_en[active_slot] ? exp_reg[active_slot][2*blk +: 2] : 2'd0;
      return slot_layout[{active_slot, sub, blk}];
   endfunction

   // Expected decode from the bus rules
   function automatic void ref_decode(output logic [MEM_ADDR_W-1:0] e_addr,
                                      output logic e_ce, output logic [7:0] e_din);
      block_t      ent;
      lookup_RAM_t rgn;
      logic [31:0] off;
      logic [31:0] msk;
      logic [7:0]  bank;
      logic        mem_acc;
      logic        unmapped;
      logic        in_win;
      logic        exp_read;
      logic        io_read;
      ent = entry_now();
      rgn = lookup_RAM[ent.ref_ram];
      msk = (32'(rgn.size) << 14) - 1;
      in_win = cpu_addr >= 16'h4000 && cpu_addr <= 16'hBFFF;
      off = 0;
      case (ent.mapper)
         MAPPER_NONE:   off = 32'(cpu_addr[13:0]) + 32'(ent.offset_ram) * 16384;
         MAPPER_LINEAR: off = 32'(cpu_addr) & msk;
         MAPPER_RAM:    off = 32'(seg_reg[cpu_addr[15:14]] & (ram_block_count - 8'd1)) * 16384
                              + 32'(cpu_addr[13:0]);
         MAPPER_KONAMI: begin
            bank = (cpu_addr[15:13] == 3'd2) ? 8'd0 : kbank[2'(cpu_addr[15:13] - 3'd2)];
            off = (32'(bank) * 8192 + 32'(cpu_addr[12:0])) & msk;
         end
         MAPPER_ASCII16: begin
            bank = abank[cpu_addr[15]];
            off = (32'(bank) * 16384 + 32'(cpu_addr[13:0])) & msk;
         end
         default: off = 0;
      endcase
      e_addr = rgn.addr + MEM_ADDR_W'(off);
      mem_acc = cpu_mreq & (cpu_rd | cpu_wr);
      exp_read = cpu_mreq & cpu_rd & (cpu_addr == 16'hFFFF) & expander_en[active_slot];
      io_read = cpu_iorq & cpu_rd & ~cpu_m1 & (cpu_addr[7:2] == 6'h3F);
      unmapped = (ent.mapper == MAPPER_UNUSED) | exp_read
               | ((ent.mapper == MAPPER_KONAMI || ent.mapper == MAPPER_ASCII16) && !in_win);
      e_ce = mem_acc & ~unmapped & ~(cpu_wr & rgn.ro);
      e_din = 8'hFF;
      if (exp_read)
         e_din = e_din & ~exp_reg[active_slot];
      if (io_read)
         e_din = e_din & (seg_reg[cpu_addr[1:0]] | SEG_HIGH);   // Upper bits read as 1
      if (mem_acc && cpu_rd && !unmapped)
         e_din = e_din & (e_addr[7:0] ^ e_addr[15:8]);   // Memory model
   endfunction

   task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
      $display("ERR %0t: %s mismatch at addr %h, got %h expected %h",
               $time, what, cpu_addr, got, exp);
      errors++;
      test_errors++;
   endtask

   task automatic mirror_writes();
      block_t ent;
      logic [1:0] idx;
      ent = entry_now();
      idx = 2'(cpu_addr[15:13] - 3'd2);
      if (cpu_mreq && cpu_wr && cpu_addr == 16'hFFFF && expander_en[active_slot])
         exp_reg[active_slot] = cpu_dout;
      if (cpu_iorq && cpu_wr && !cpu_m1 && cpu_addr[7:2] == 6'h3F)
         seg_reg[cpu_addr[1:0]] = cpu_dout & ~SEG_HIGH;
      if (cpu_mreq && cpu_wr && ent.mapper == MAPPER_KONAMI
          && cpu_addr >= 16'h6000 && cpu_addr <= 16'hBFFF)
         kbank[idx] = cpu_dout;
      if (cpu_mreq && cpu_wr && ent.mapper == MAPPER_ASCII16) begin
         if (cpu_addr[15:11] == 5'h0C) abank[0] = cpu_dout;
         if (cpu_addr[15:11] == 5'h0E) abank[1] = cpu_dout;
      end
   endtask

   initial begin
      errors = 0;
      checks = 0;
      test_errors = 0;
   end

   always @(posedge clk) begin
      logic [MEM_ADDR_W-1:0] e_addr;
      logic                  e_ce;
      logic            [7:0] e_din;
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            exp_reg[i] = 8'h00;
            seg_reg[i] = 8'(3 - i);
            kbank[i] = 8'(i);
         end
         abank[0] = 8'h00;
         abank[1] = 8'h00;
      end else begin
         ref_decode(e_addr, e_ce, e_din);
         checks++;
         if (ram_ce !== e_ce) mismatch("ram_ce", 32'(ram_ce), 32'(e_ce));
         if (e_ce && ram_addr !== e_addr) mismatch("ram_addr", 32'(ram_addr), 32'(e_addr));
         if (cpu_mreq && ram_rnw !== ~cpu_wr) mismatch("ram_rnw", 32'(ram_rnw), 32'(~cpu_wr));
         if (ram_din !== cpu_dout) mismatch("ram_din", 32'(ram_din), 32'(cpu_dout));
         if (cpu_din !== e_din) mismatch("cpu_din", 32'(cpu_din), 32'(e_din));
         mirror_writes();
         if (test_end) begin
            $display("test %0d finished with %0d mismatches", test_num, test_errors);
            test_errors = 0;
         end
      end
   end

endmodule

//--- tb/msx_slots_tb.sv
module msx_slots_tb import msx_mapper_pkg::*, msx_cfg_pkg::*;;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_ACC = 40;   // Random accesses per burst
   localparam int RUN_CYCLES = 8 * (3 * N_ACC + 16) + 20;
   localparam int SEG_BITS = 6;   // RAM mapper segment width

   logic                  clk;
   logic                  reset;
   logic           [15:0] cpu_addr;
   logic            [7:0] cpu_dout;
   logic            [7:0] cpu_din;
   logic                  cpu_wr;
   logic                  cpu_rd;
   logic                  cpu_mreq;
   logic                  cpu_iorq;
   logic                  cpu_m1;
   logic            [1:0] active_slot;
   logic            [3:0] expander_en;
   logic            [7:0] ram_block_count;
   block_t                slot_layout [LAYOUT_ENTRIES];
   lookup_RAM_t           lookup_RAM [RAM_REGIONS];
   logic [MEM_ADDR_W-1:0] ram_addr;
   logic            [7:0] ram_din;
   logic            [7:0] ram_dout;
   logic                  ram_rnw;
   logic                  ram_ce;
   logic                  test_end;
   int                    test_num;
   int                    errors;
   int                    checks;
   integer                seed;

   msx_slots #(.RAM_SEG_BITS(SEG_BITS)) u_dut (.*);

   msx_slots_checker #(.RAM_SEG_BITS(SEG_BITS)) u_checker (.*);

   assign ram_dout = ram_addr[7:0] ^ ram_addr[15:8];   // Memory model

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic set_entry(input logic [1:0] slot, input logic [1:0] sub, input logic [1:0] blk,
                            input mapper_typ_t kind, input logic [3:0] rgn,
                            input logic [1:0] off);
      slot_layout[{slot, sub, blk}] = '{mapper: kind, ref_ram: rgn, offset_ram: off};
   endtask

   task automatic bus_cycle(input logic [15:0] a, input logic mem, input logic wr,
                            input logic [7:0] d);
      @(negedge clk);
      cpu_addr = a;
      cpu_dout = d;
      cpu_mreq = mem;
      cpu_iorq = ~mem;
      cpu_wr = wr;
      cpu_rd = ~wr;
   endtask

   task automatic random_mem(input int n);
      int r;
      for (int i = 0; i < n; i++) begin
         r = $random(seed);
         bus_cycle(r[15:0], 1'b1, r[16], r[31:24]);
      end
   endtask

   task automatic finish_test();
      @(negedge clk);
      cpu_mreq = 1'b0;
      cpu_iorq = 1'b0;
      cpu_rd = 1'b0;
      cpu_wr = 1'b0;
      test_end = 1'b1;
      @(negedge clk);
      test_end = 1'b0;
      test_num++;
   endtask

   initial begin
      #(RUN_CYCLES * 100);
      $display("Timeout: the stimulus did not finish within %0d cycles", RUN_CYCLES);
      $display("Verification failed");
      $finish;
   end

   initial begin
      int r;
      seed = 32'ha64;
      reset = 1'b1;
      cpu_addr = '0;
      cpu_dout = '0;
      cpu_wr = 1'b0;
      cpu_rd = 1'b0;
      cpu_mreq = 1'b0;
      cpu_iorq = 1'b0;
      cpu_m1 = 1'b0;
      active_slot = 2'd0;
      expander_en = 4'b0100;
      ram_block_count = 8'd8;
      test_end = 1'b0;
      test_num = 1;
      for (int i = 0; i < LAYOUT_ENTRIES; i++)
         slot_layout[i] = '{mapper: MAPPER_UNUSED, ref_ram: 4'd0, offset_ram: 2'd0};
      for (int i = 0; i < RAM_REGIONS; i++)
         lookup_RAM[i] = '{addr: '0, size: 16'd0, ro: 1'b0};
      lookup_RAM[0] = '{addr: 27'h0100000, size: 16'd4, ro: 1'b1};
      lookup_RAM[1] = '{addr: 27'h0200000, size: 16'd8, ro: 1'b1};
      lookup_RAM[2] = '{addr: 27'h0400000, size: 16'd2, ro: 1'b0};   // 32 KB, wraps the CPU space
      lookup_RAM[3] = '{addr: 27'h0600000, size: 16'd16, ro: 1'b1};
      lookup_RAM[4] = '{addr: 27'h0000000, size: 16'd16, ro: 1'b0};
      lookup_RAM[5] = '{addr: 27'h0000000, size: 16'd16, ro: 1'b1};
      for (int b = 0; b < 4; b++) begin
         if (b < 3)
            set_entry(2'd0, 2'd0, 2'(b), MAPPER_NONE, 4'd0, 2'(b));   // Block 3 left UNUSED
         set_entry(2'd1, 2'd0, 2'(b), MAPPER_KONAMI, 4'd1, 2'd0);
         set_entry(2'd2, 2'd0, 2'(b), MAPPER_LINEAR, 4'd2, 2'd0);
         set_entry(2'd2, 2'd1, 2'(b), MAPPER_ASCII16, 4'd3, 2'd0);
         set_entry(2'd3, 2'd0, 2'(b), MAPPER_RAM, (b == 0) ? 4'd5 : 4'd4, 2'd0);
      end
      repeat (5) @(negedge clk);
      reset = 1'b0;

      // Expander in slot 2, blocks 1 and 3 on subslot 1
      active_slot = 2'd2;
      bus_cycle(16'hFFFF, 1'b1, 1'b1, 8'h44);
      bus_cycle(16'hFFFF, 1'b1, 1'b0, 8'h00);
      random_mem(N_ACC);
      finish_test();

      // NONE and LINEAR
      active_slot = 2'd0;
      random_mem(N_ACC);
      active_slot = 2'd2;
      bus_cycle(16'hFFFF, 1'b1, 1'b1, 8'h00);
      random_mem(N_ACC);
      finish_test();

      // Konami, reads through the reset banks first
      active_slot = 2'd1;
      for (int i = 0; i < N_ACC; i++) begin
         r = $random(seed);
         bus_cycle(r[15:0], 1'b1, 1'b0, 8'h00);
      end
      for (int i = 0; i < N_ACC; i++) begin
         r = $random(seed);
         bus_cycle({3'(2 + (i % 3) + 1), r[12:0]}, 1'b1, 1'b1, r[23:16]);
         bus_cycle(r[31:16], 1'b1, 1'b0, 8'h00);
      end
      finish_test();

      // ASCII16 in every block of slot 2
      active_slot = 2'd2;
      bus_cycle(16'hFFFF, 1'b1, 1'b1, 8'h55);
      for (int i = 0; i < N_ACC; i++) begin
         r = $random(seed);
         bus_cycle({3'b011, r[0], 1'b0, 11'(r[15:5])}, 1'b1, 1'b1, r[23:16]);   // 6000 or 7000
         bus_cycle({r[31], ~r[31], r[29:16]}, 1'b1, 1'b0, 8'h00);
      end
      finish_test();

      // RAM mapper through the I/O ports
      active_slot = 2'd3;
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         bus_cycle({8'h00, 6'h3F, 2'(i)}, 1'b0, 1'b1, r[7:0]);
         bus_cycle({8'h00, 6'h3F, 2'(i)}, 1'b0, 1'b0, 8'h00);
         random_mem(N_ACC / 8);
      end
      random_mem(N_ACC);
      finish_test();

      // UNUSED block 3 of slot 0
      active_slot = 2'd0;
      for (int i = 0; i < N_ACC; i++) begin
         r = $random(seed);
         bus_cycle({2'b11, r[13:0]}, 1'b1, r[16], r[31:24]);
      end
      finish_test();

      @(negedge clk);
      $display("Summary: %0d tests, %0d checks, %0d mismatches", test_num - 1, checks, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

//--- msx_slots.f
verilog/msx_mapper_pkg.sv
verilog/msx_cfg_pkg.sv
verilog/slot_expander.sv
verilog/msx2_ram_mapper.sv
verilog/cart_konami.sv
verilog/cart_ascii16.sv
verilog/msx_slots.sv
tb/msx_slots_properties.sv
tb/msx_slots_checker.sv
tb/msx_slots_tb.sv

//--- Bender.yml
package:
  name: msx_slots

sources:
  - verilog/msx_mapper_pkg.sv
  - verilog/msx_cfg_pkg.sv
  - verilog/slot_expander.sv
  - verilog/msx2_ram_mapper.sv
  - verilog/cart_konami.sv
  - verilog/cart_ascii16.sv
  - verilog/msx_slots.sv
  - target: simulation
    files:
      - tb/msx_slots_properties.sv
      - tb/msx_slots_checker.sv
      - tb/msx_slots_tb.sv
